// ==== design/execPkg.sv ====
package execPkg;

   // Word width, fixed by the instruction format
   localparam int DataWidth = 32;

   // Opcode bit that selects the immediate layout
   localparam int ImmSelBit = 3;

   // One issue word, read through either layout
   typedef union packed {
      struct packed {
         logic [5:0]  opcode;
         logic [4:0]  rd;
         logic [4:0]  ra;
         logic [4:0]  rb;
         logic [10:0] func;
      } regForm;
      struct packed {
         logic [5:0]  opcode;
         logic [4:0]  rd;
         logic [4:0]  ra;
         logic [15:0] imm;
      } immForm;
   } instrWord;

   // Unit class, opcode bits 5:4
   typedef enum logic [1:0] {
      classAlu   = 2'd0,
      classMul   = 2'd1,
      classShift = 2'd2,
      classRsv   = 2'd3
   } opClass;

   // ALU function, opcode bits 2:0
   typedef enum logic [2:0] {
      aluAdd      = 3'd0,
      aluSub      = 3'd1,
      aluAnd      = 3'd2,
      aluOr       = 3'd3,
      aluXor      = 3'd4,
      aluAndNot   = 3'd5,
      aluPassA    = 3'd6,
      aluLessThan = 3'd7
   } aluFunc;

   // Shift kind, opcode bits 1:0; code 3 behaves as sll
   typedef enum logic [1:0] {
      shiftSll = 2'd0,
      shiftSrl = 2'd1,
      shiftSra = 2'd2
   } shiftFunc;

endpackage

// ==== design/opDecode.sv ====
`timescale 1ns/1ps

module opDecode import execPkg::*; (
   input  instrWord               instr,
   input  logic [DataWidth-1:0]   opB,
   output logic [DataWidth-1:0]   opBOf,
   output opClass                 cls,
   output aluFunc                 aluOp,
   output shiftFunc               shiftOp,
   output logic [4:0]             rd
);

   logic                 immSel;
   logic [DataWidth-1:0] immExt;

   // Opcode and rd sit at the same place in both layouts
   assign immSel = instr.regForm.opcode[ImmSelBit];
   assign rd     = instr.regForm.rd;

   // Class and function fields
   assign cls     = opClass'(instr.regForm.opcode[5:4]);
   assign aluOp   = aluFunc'(instr.regForm.opcode[2:0]);
   assign shiftOp = shiftFunc'(instr.regForm.opcode[1:0]);

   // Immediate, sign extended to a full word
   assign immExt = {{(DataWidth - 16){instr.immForm.imm[15]}}, instr.immForm.imm};

   // Second operand for every unit
   assign opBOf = immSel ? immExt : opB;

endmodule

// ==== design/mulUnit.sv ====
`timescale 1ns/1ps

module mulUnit import execPkg::*; (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 dena,
   input  logic [DataWidth-1:0] opA,
   input  logic [DataWidth-1:0] opB,
   output logic [DataWidth-1:0] mulResult
);

   // Product pipeline, low word only
   logic [DataWidth-1:0] mulStage1;
   logic [DataWidth-1:0] mulStage2;

   always_ff @(posedge gclk) begin
      if (grst) begin
         mulStage1 <= '0;
         mulStage2 <= '0;
      end else if (dena) begin
         // Multiplier structure left to synthesis
         mulStage1 <= opA * opB;
         // Second register adds the slack for a slow multiplier
         mulStage2 <= mulStage1;
      end
   end

   assign mulResult = mulStage2;

endmodule

// ==== design/shiftUnit.sv ====
`timescale 1ns/1ps

module shiftUnit import execPkg::*; (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 dena,
   input  logic [DataWidth-1:0] opA,
   input  logic [DataWidth-1:0] opB,
   input  shiftFunc             shiftOp,
   output logic [DataWidth-1:0] shiftResult
);

   logic [4:0]           shAmt;
   logic [DataWidth-1:0] shiftNext;
   logic [DataWidth-1:0] shiftStage1;
   logic [DataWidth-1:0] shiftStage2;

   // Amount from the low five bits of the second operand
   assign shAmt = opB[4:0];

   // Barrel shifter
   always_comb begin
      case (shiftOp)
         shiftSrl: shiftNext = opA >> shAmt;
         shiftSra: shiftNext = $signed(opA) >>> shAmt;
         // sll, and code 3 as well
         default:  shiftNext = opA << shAmt;
      endcase
   end

   // Delay stage keeps depth equal to the multiplier
   always_ff @(posedge gclk) begin
      if (grst) begin
         shiftStage1 <= '0;
         shiftStage2 <= '0;
      end else if (dena) begin
         shiftStage1 <= shiftNext;
         shiftStage2 <= shiftStage1;
      end
   end

   assign shiftResult = shiftStage2;

endmodule

// ==== design/aluSelect.sv ====
`timescale 1ns/1ps

module aluSelect import execPkg::*; (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 dena,
   input  logic [DataWidth-1:0] opA,
   input  logic [DataWidth-1:0] opB,
   input  aluFunc               aluOp,
   input  opClass               cls,
   input  logic [4:0]           rd,
   input  logic [DataWidth-1:0] mulResult,
   input  logic [DataWidth-1:0] shiftResult,
   output logic [DataWidth-1:0] resultData,
   output logic [4:0]           resultRd
);

   logic [DataWidth-1:0] aluNext;
   logic [DataWidth-1:0] aluStage1;
   logic [DataWidth-1:0] aluStage2;
   opClass               clsStage1;
   opClass               clsStage2;
   logic [4:0]           rdStage1;
   logic [4:0]           rdStage2;

   // ALU functions
   always_comb begin
      case (aluOp)
         aluAdd:      aluNext = opA + opB;
         aluSub:      aluNext = opA - opB;
         aluAnd:      aluNext = opA & opB;
         aluOr:       aluNext = opA | opB;
         aluXor:      aluNext = opA ^ opB;
         aluAndNot:   aluNext = opA & ~opB;
         aluPassA:    aluNext = opA;
         // Signed compare, result 1 or 0
         aluLessThan: aluNext = {{(DataWidth - 1){1'b0}}, $signed(opA) < $signed(opB)};
         default:     aluNext = '0;
      endcase
   end

   // Result, class and destination move together
   always_ff @(posedge gclk) begin
      if (grst) begin
         aluStage1 <= '0;
         aluStage2 <= '0;
         clsStage1 <= classAlu;
         clsStage2 <= classAlu;
         rdStage1  <= '0;
         rdStage2  <= '0;
      end else if (dena) begin
         aluStage1 <= aluNext;
         aluStage2 <= aluStage1;
         clsStage1 <= cls;
         clsStage2 <= clsStage1;
         rdStage1  <= rd;
         rdStage2  <= rdStage1;
      end
   end

   // Final pick by carried class
   always_comb begin
      case (clsStage2)
         classAlu:   resultData = aluStage2;
         classMul:   resultData = mulResult;
         classShift: resultData = shiftResult;
         // Reserved class
         default:    resultData = '0;
      endcase
   end

   assign resultRd = rdStage2;

endmodule

// ==== design/execCtrl.sv ====
`timescale 1ns/1ps

module execCtrl import execPkg::*; (
   input  logic   gclk,
   input  logic   grst,
   input  logic   instrValid,
   input  opClass cls,
   input  logic   haveCredit,
   output logic   dena,
   output logic   accept,
   output logic   resultValid
);

   // Pipeline states
   localparam logic [1:0] sIdle    = 2'd0;
   localparam logic [1:0] sBusy    = 2'd1;
   localparam logic [1:0] sBlocked = 2'd2;

   logic       valid1;
   logic       valid2;
   logic [1:0] state;

   // State from the occupancy bits and the credit seen now
   always_comb begin
      if (valid2 && !haveCredit) begin
         // Finished result with nowhere to go
         state = sBlocked;
      end else if (valid1 || valid2) begin
         state = sBusy;
      end else begin
         state = sIdle;
      end
   end

   // Whole pipeline freezes while blocked
   assign dena   = (state != sBlocked);
   assign accept = dena;

   // Delivery costs one credit
   assign resultValid = (state == sBusy) && valid2;

   // Occupancy shifts with the data units
   always_ff @(posedge gclk) begin
      if (grst) begin
         valid1 <= 1'b0;
         valid2 <= 1'b0;
      end else if (dena) begin
         valid1 <= instrValid;
         valid2 <= valid1;
      end
   end

   // Reserved class never enters the pipeline
   aNoRsv: assert property (@(posedge gclk) disable iff (grst)
      (instrValid && accept) |-> (cls != classRsv));

endmodule

// ==== design/creditCounter.sv ====
`timescale 1ns/1ps

module creditCounter #(
   parameter int Credits = 4
) (
   input  logic gclk,
   input  logic grst,
   input  logic spend,
   input  logic refund,
   output logic haveCredit
);

   localparam int CountWidth = $clog2(Credits + 1);

   logic [CountWidth-1:0] count;

   // Spend and refund together cancel out
   always_ff @(posedge gclk) begin
      if (grst) begin
         count <= CountWidth'(Credits);
      end else if (spend && !refund) begin
         count <= count - CountWidth'(1);
      end else if (refund && !spend) begin
         count <= count + CountWidth'(1);
      end
   end

   assign haveCredit = (count != '0);

   // Consumer never returns more than it took
   aNoOverflow: assert property (@(posedge gclk) disable iff (grst)
      (refund && !spend) |-> (count < CountWidth'(Credits)));

   // Control side must respect an empty counter
   aNoSpendEmpty: assert property (@(posedge gclk) disable iff (grst)
      spend |-> (count != '0));

endmodule

// ==== design/execTop.sv ====
`timescale 1ns/1ps

module execTop import execPkg::*; #(
   parameter int Credits = 4
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 instrValid,
   input  instrWord             instr,
   input  logic [DataWidth-1:0] opA,
   input  logic [DataWidth-1:0] opB,
   output logic                 accept,
   output logic                 resultValid,
   output logic [DataWidth-1:0] resultData,
   output logic [4:0]           resultRd,
   input  logic                 creditReturn
);

   // Decoded fields
   logic [DataWidth-1:0] opBOf;
   opClass               cls;
   aluFunc               aluOp;
   shiftFunc             shiftOp;
   logic [4:0]           rd;

   // Control
   logic                 dena;
   logic                 haveCredit;

   // Stage-2 unit results
   logic [DataWidth-1:0] mulResult;
   logic [DataWidth-1:0] shiftResult;

   opDecode uDecode (
      .instr   (instr),
      .opB     (opB),
      .opBOf   (opBOf),
      .cls     (cls),
      .aluOp   (aluOp),
      .shiftOp (shiftOp),
      .rd      (rd)
   );

   execCtrl uCtrl (
      .gclk        (gclk),
      .grst        (grst),
      .instrValid  (instrValid),
      .cls         (cls),
      .haveCredit  (haveCredit),
      .dena        (dena),
      .accept      (accept),
      .resultValid (resultValid)
   );

   // Each delivered result spends, each returned slot refunds
   creditCounter #(
      .Credits (Credits)
   ) uCredit (
      .gclk       (gclk),
      .grst       (grst),
      .spend      (resultValid),
      .refund     (creditReturn),
      .haveCredit (haveCredit)
   );

   mulUnit uMul (
      .gclk      (gclk),
      .grst      (grst),
      .dena      (dena),
      .opA       (opA),
      .opB       (opBOf),
      .mulResult (mulResult)
   );

   shiftUnit uShift (
      .gclk        (gclk),
      .grst        (grst),
      .dena        (dena),
      .opA         (opA),
      .opB         (opBOf),
      .shiftOp     (shiftOp),
      .shiftResult (shiftResult)
   );

   aluSelect uAlu (
      .gclk        (gclk),
      .grst        (grst),
      .dena        (dena),
      .opA         (opA),
      .opB         (opBOf),
      .aluOp       (aluOp),
      .cls         (cls),
      .rd          (rd),
      .mulResult   (mulResult),
      .shiftResult (shiftResult),
      .resultData  (resultData),
      .resultRd    (resultRd)
   );

endmodule

// ==== testbench/execChecker.sv ====
`timescale 1ns/1ps

module execChecker import execPkg::*; #(
   parameter int Credits = 4
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 instrValid,
   input  logic [DataWidth-1:0] instr,
   input  logic [DataWidth-1:0] opA,
   input  logic [DataWidth-1:0] opB,
   input  logic                 accept,
   input  logic                 resultValid,
   input  logic [DataWidth-1:0] resultData,
   input  logic [4:0]           resultRd,
   input  logic                 creditReturn,
   input  logic                 runDone,
   output int                   errorCount,
   output int                   resultCount,
   output int                   pendingCount
);

   // Expected results in issue order, {rd, data}
   logic [36:0] expQ[$];
   logic [36:0] head;
   // Model of stage occupancy and credits
   logic        mv1;
   logic        mv2;
   logic        expValid;
   logic        expAccept;
   int          mCredits;
   int          errors = 0;
   int          results = 0;
   int          pending = 0;
   logic        doneSeen = 1'b0;

   assign errorCount   = errors;
   assign resultCount  = results;
   assign pendingCount = pending;

   // Reference result, straight from the instruction format rules
   function automatic logic [31:0] expectResult(input logic [31:0] w, input logic [31:0] a,
                                                input logic [31:0] bReg);
      logic [5:0]  opc;
      logic [31:0] b;
      logic [4:0]  sh;
      logic        lt;
      opc = w[31:26];
      // Immediate form when opcode bit 3 is set
      b   = opc[3] ? {{16{w[15]}}, w[15:0]} : bReg;
      sh  = b[4:0];
      // Signed less-than from sign bits, then magnitude
      lt  = (a[31] != b[31]) ? a[31] : (a < b);
      case (opc[5:4])
         2'd0: begin
            case (opc[2:0])
               3'd0:    return a + b;
               3'd1:    return a - b;
               3'd2:    return a & b;
               3'd3:    return a | b;
               3'd4:    return a ^ b;
               3'd5:    return a & ~b;
               3'd6:    return a;
               default: return {31'b0, lt};
            endcase
         end
         2'd1: return a * b;
         2'd2: begin
            case (opc[1:0])
               2'd1:    return a >> sh;
               // Arithmetic right as logical right plus sign fill
               2'd2:    return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
               default: return a << sh;
            endcase
         end
         // Reserved class gives zero
         default: return 32'h0;
      endcase
   endfunction

   // Sample mid-cycle where every DUT output is settled
   always @(negedge gclk) begin
      if (grst) begin
         mv1      = 1'b0;
         mv2      = 1'b0;
         mCredits = Credits;
         expQ.delete();
      end else begin
         expValid  = mv2 && (mCredits > 0);
         expAccept = !(mv2 && (mCredits == 0));
         if (resultValid !== expValid) begin
            $display("mismatch at %0t: resultValid expected %b got %b", $time, expValid,
                     resultValid);
            errors++;
         end
         if (accept !== expAccept) begin
            $display("mismatch at %0t: accept expected %b got %b", $time, expAccept, accept);
            errors++;
         end
         if (resultValid === 1'b1) begin
            results++;
            if (mCredits == 0) begin
               $display("error at %0t: result delivered with no credit left", $time);
               errors++;
            end
            if (expQ.size() == 0) begin
               $display("error at %0t: result delivered with nothing in flight", $time);
               errors++;
            end else begin
               head = expQ.pop_front();
               if (resultData !== head[31:0]) begin
                  $display("mismatch at %0t: resultData expected %h got %h", $time,
                           head[31:0], resultData);
                  errors++;
               end
               if (resultRd !== head[36:32]) begin
                  $display("mismatch at %0t: resultRd expected %0d got %0d", $time,
                           head[36:32], resultRd);
                  errors++;
               end
            end
            mCredits--;
         end
         if (creditReturn === 1'b1) begin
            mCredits++;
         end
         // Pipeline moves unless stage 2 waits for a credit
         if (expAccept) begin
            mv2 = mv1;
            mv1 = instrValid;
         end
         if (instrValid && accept) begin
            expQ.push_back({instr[25:21], expectResult(instr, opA, opB)});
         end
         if (runDone && !doneSeen) begin
            doneSeen = 1'b1;
            if (expQ.size() != 0) begin
               $display("error: %0d issued results were never delivered", expQ.size());
               errors++;
            end
         end
      end
      pending = expQ.size();
   end

endmodule

// ==== testbench/execTb.sv ====
`timescale 1ns/1ps

module execTb import execPkg::*; ();

   localparam int Credits = 4;
   // Instructions over all tests and the cycle limit they allow
   localparam int TotalInstr    = 32 + 16 + 24 + 40 + 6 + 6;
   localparam int TimeoutCycles = TotalInstr * 12 + 200;

   logic                 gclk = 1'b0;
   logic                 grst;
   logic                 instrValid;
   instrWord             instr;
   logic [DataWidth-1:0] opA;
   logic [DataWidth-1:0] opB;
   logic                 accept;
   logic                 resultValid;
   logic [DataWidth-1:0] resultData;
   logic [4:0]           resultRd;
   logic                 creditReturn = 1'b0;
   logic                 runDone;

   int   errorCount;
   int   resultCount;
   int   pendingCount;
   int   seed = 31;
   int   cycleCount = 0;
   int   errorsAtStart;
   int   resultsAtStart;
   // Consumer model
   int   creditDelay;
   logic holdCredits;
   logic giveCredit = 1'b0;
   int   owed[$];
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] r;
   logic [15:0] low;

   always #10 gclk = ~gclk;

   execTop #(
      .Credits (Credits)
   ) u_dut (
      .gclk         (gclk),
      .grst         (grst),
      .instrValid   (instrValid),
      .instr        (instr),
      .opA          (opA),
      .opB          (opB),
      .accept       (accept),
      .resultValid  (resultValid),
      .resultData   (resultData),
      .resultRd     (resultRd),
      .creditReturn (creditReturn)
   );

   execChecker #(
      .Credits (Credits)
   ) uChecker (
      .gclk         (gclk),
      .grst         (grst),
      .instrValid   (instrValid),
      .instr        (instr),
      .opA          (opA),
      .opB          (opB),
      .accept       (accept),
      .resultValid  (resultValid),
      .resultData   (resultData),
      .resultRd     (resultRd),
      .creditReturn (creditReturn),
      .runDone      (runDone),
      .errorCount   (errorCount),
      .resultCount  (resultCount),
      .pendingCount (pendingCount)
   );

   // Each delivered result owes one credit due creditDelay cycles later
   always @(negedge gclk) begin
      if (grst) begin
         owed.delete();
         giveCredit = 1'b0;
      end else begin
         if (resultValid) begin
            owed.push_back(cycleCount + creditDelay);
         end
         if (!holdCredits && owed.size() > 0 && owed[0] <= cycleCount) begin
            giveCredit = 1'b1;
            void'(owed.pop_front());
         end else begin
            giveCredit = 1'b0;
         end
      end
   end

   // One-cycle credit pulse driven just after the edge
   always @(posedge gclk) begin
      #1;
      creditReturn = giveCredit;
   end

   // Run limit
   always @(posedge gclk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > TimeoutCycles) begin
         $display("error: run did not finish within %0d cycles", TimeoutCycles);
         $display("Done: errors found");
         $finish;
      end
   end

   // Hold one instruction until it transfers
   task automatic issueOne(input logic [5:0] opc, input logic [31:0] opAVal,
                           input logic [31:0] opBVal, input logic [15:0] lowBits);
      logic taken;
      logic [4:0] rdPick;
      logic [4:0] raPick;
      rdPick     = 5'($random(seed));
      raPick     = 5'($random(seed));
      instrValid = 1'b1;
      instr      = {opc, rdPick, raPick, lowBits};
      opA        = opAVal;
      opB        = opBVal;
      do begin
         @(negedge gclk);
         taken = accept;
         @(posedge gclk);
         #1;
      end while (!taken);
      instrValid = 1'b0;
   endtask

   task automatic waitCycles(input int n);
      repeat (n) @(posedge gclk);
      #1;
   endtask

   // Wait until every result and every credit is back
   task automatic drain();
      @(negedge gclk);
      #1;
      while (pendingCount != 0 || owed.size() != 0 || giveCredit || creditReturn) begin
         @(negedge gclk);
         #1;
      end
      @(posedge gclk);
      #1;
   endtask

   task automatic pulseReset();
      grst = 1'b1;
      repeat (4) @(posedge gclk);
      #1;
      grst = 1'b0;
   endtask

   task automatic beginTest();
      errorsAtStart  = errorCount;
      resultsAtStart = resultCount;
   endtask

   task automatic endTest(input string name);
      $display("%s finished: %0d results, %0d errors", name, resultCount - resultsAtStart,
               errorCount - errorsAtStart);
   endtask

   initial begin
      instrValid  = 1'b0;
      instr       = '0;
      opA         = '0;
      opB         = '0;
      runDone     = 1'b0;
      holdCredits = 1'b0;
      creditDelay = 2;
      pulseReset();

      // ALU in both forms with negative immediates in the second half
      beginTest();
      for (int i = 0; i < 32; i++) begin
         low = 16'($random(seed));
         if (i >= 16) begin
            low[15] = 1'b1;
         end
         issueOne({2'b00, 4'(i % 16)}, $random(seed), $random(seed), low);
      end
      drain();
      endTest("aluOps");

      // Multiply with zero and all-ones corners
      beginTest();
      for (int i = 0; i < 16; i++) begin
         a   = (i == 0) ? 32'h0 : $random(seed);
         b   = (i == 1) ? 32'h0 : $random(seed);
         low = 16'($random(seed));
         if (i == 2 || i == 9) begin
            a   = 32'hFFFF_FFFF;
            b   = 32'hFFFF_FFFF;
            low = 16'hFFFF;
         end
         issueOne({2'b01, 4'(i % 16)}, a, b, low);
      end
      drain();
      endTest("mulOps");

      // Shifts of every kind with bit 2 of the step picking a negative value
      beginTest();
      for (int i = 0; i < 24; i++) begin
         a = $random(seed);
         a[31] = i[2];
         b = (i == 0) ? 32'd0 : ((i == 1) ? 32'd31 : $random(seed));
         issueOne({2'b10, 4'(i % 16)}, a, b, 16'($random(seed)));
      end
      drain();
      endTest("shiftOps");

      // Mixed classes back to back with credits coming straight back
      beginTest();
      creditDelay = 0;
      for (int i = 0; i < 40; i++) begin
         r = $random(seed);
         issueOne({2'(r % 32'd3), 4'(r[7:4])}, $random(seed), $random(seed),
                  16'($random(seed)));
      end
      drain();
      endTest("mixedIssue");

      // Withheld credits stall the pipe with two items inside
      beginTest();
      holdCredits = 1'b1;
      for (int i = 0; i < 6; i++) begin
         issueOne({2'b00, 4'(i)}, $random(seed), $random(seed), 16'($random(seed)));
      end
      waitCycles(10);
      holdCredits = 1'b0;
      drain();
      endTest("backPressure");

      // Fresh reset so only the initial credits are spent
      beginTest();
      pulseReset();
      holdCredits = 1'b1;
      for (int i = 0; i < 6; i++) begin
         issueOne({2'b01, 4'(i)}, $random(seed), $random(seed), 16'($random(seed)));
      end
      waitCycles(10);
      $display("resetState: %0d results before the first credit returned",
               resultCount - resultsAtStart);
      holdCredits = 1'b0;
      drain();
      endTest("resetState");

      runDone = 1'b1;
      @(negedge gclk);
      #1;
      $display("Totals: %0d results, %0d errors", resultCount, errorCount);
      if (errorCount == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== all.f ====
design/execPkg.sv
design/opDecode.sv
design/mulUnit.sv
design/shiftUnit.sv
design/aluSelect.sv
design/execCtrl.sv
design/creditCounter.sv
design/execTop.sv
testbench/execChecker.sv
testbench/execTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= execTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
